// File: design/keyboard_pkg.sv
// Keyboard encodings
`default_nettype none

package keyboard_pkg;

	typedef logic [7:0] key_t;     // Bits 0..6 do..si
	typedef logic [1:0] pitch_t;
	typedef logic [2:0] mode_t;
	typedef logic [4:0] note_t;    // 0 is silence
	typedef logic [7:0] led_t;

	localparam pitch_t PITCH_MID  = 2'b00;
	localparam pitch_t PITCH_LOW  = 2'b01;
	localparam pitch_t PITCH_HIGH = 2'b10;

	localparam mode_t MODE_LEARN = 3'b111;  // Auto and manual are idle here

	localparam int DEGREES    = 7;
	localparam int NOTE_COUNT = 21;

	// C3 to B5, indexed by note code minus one
	localparam int NOTE_HZ [NOTE_COUNT] = '{
		131, 147, 165, 175, 196, 220, 247,
		262, 294, 330, 349, 392, 440, 494,
		523, 587, 659, 698, 784, 880, 988
	};

	// Scale degree of a nonzero note, 0 is do
	function automatic logic [2:0] note_degree(note_t n);
		return 3'((n - 5'd1) % DEGREES);
	endfunction

	// Octave group of a nonzero note, 0 is low
	function automatic logic [1:0] note_octave(note_t n);
		return 2'((n - 5'd1) / DEGREES);
	endfunction

	// Pitch selector for an octave group
	function automatic pitch_t octave_pitch(logic [1:0] group);
		case (group)
			2'd0:    return PITCH_LOW;
			2'd2:    return PITCH_HIGH;
			default: return PITCH_MID;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: design/song_pkg.sv
// Song tables
`default_nettype none

package song_pkg;

	import keyboard_pkg::*;

	typedef logic [1:0] song_id_t;
	typedef logic [4:0] step_t;
	typedef logic       len_t;

	localparam song_id_t SONG_TWINKLE = 2'd0;
	localparam song_id_t SONG_ODE     = 2'd1;

	localparam int SONG_SLOTS = 4;   // Every song_id_t value
	localparam int SONG_COUNT = 2;   // Slots 2 and 3 are empty
	localparam int MAX_STEPS  = 16;

	localparam len_t LEN_SINGLE = 1'b0;
	localparam len_t LEN_DOUBLE = 1'b1;  // Half the hold time

	localparam step_t SONG_LAST [SONG_SLOTS] = '{
		5'd13,
		5'd14,
		5'd0,
		5'd0
	};

	// Middle octave codes 8..14 are do..si, 0 is a rest
	localparam note_t SONG_NOTE [SONG_SLOTS][MAX_STEPS] = '{
		// Twinkle Twinkle
		'{
			8, 8, 12, 12, 13, 13, 12, 0,
			11, 11, 10, 10, 9, 8, 0, 0
		},
		// Ode to Joy
		'{
			10, 10, 11, 12, 12, 11, 10, 9,
			8, 8, 9, 10, 10, 9, 9, 0
		},
		'{
			0, 0, 0, 0, 0, 0, 0, 0,
			0, 0, 0, 0, 0, 0, 0, 0
		},
		'{
			0, 0, 0, 0, 0, 0, 0, 0,
			0, 0, 0, 0, 0, 0, 0, 0
		}
	};

	localparam len_t SONG_LEN [SONG_SLOTS][MAX_STEPS] = '{
		'{
			0, 0, 0, 0, 0, 0, 0, 0,
			0, 0, 0, 0, 0, 0, 0, 0
		},
		'{
			0, 0, 0, 0, 0, 0, 0, 0,
			0, 0, 0, 0, 0, 1, 0, 0
		},
		'{
			0, 0, 0, 0, 0, 0, 0, 0,
			0, 0, 0, 0, 0, 0, 0, 0
		},
		'{
			0, 0, 0, 0, 0, 0, 0, 0,
			0, 0, 0, 0, 0, 0, 0, 0
		}
	};

endpackage

`default_nettype wire

// File: design/key_decoder.sv
// Key to note decoder
`timescale 1ns/1ns
`default_nettype none

module key_decoder (
	input  keyboard_pkg::key_t   key,
	input  keyboard_pkg::pitch_t pitch,
	output keyboard_pkg::note_t  pressed_note
);

	import keyboard_pkg::*;

	logic [2:0] degree;
	logic [1:0] group;
	logic       one_key;
	logic       pitch_ok;

	assign one_key = $onehot(key[DEGREES-1:0]);  // Bit 7 is ignored

	always_comb begin
		degree = '0;
		for (int i = 0; i < DEGREES; i++) begin
			if (key[i]) degree = 3'(i);
		end
	end

	always_comb begin
		pitch_ok = 1'b1;
		case (pitch)
			PITCH_LOW:  group = 2'd0;
			PITCH_MID:  group = 2'd1;
			PITCH_HIGH: group = 2'd2;
			default: begin
				group    = 2'd0;
				pitch_ok = 1'b0;
			end
		endcase
	end

	assign pressed_note = (one_key && pitch_ok) ?
		note_t'(group) * note_t'(DEGREES) + note_t'(degree) + 5'd1 : '0;

endmodule

`default_nettype wire

// File: design/lesson_tracker.sv
// Lesson step tracker
`timescale 1ns/1ns
`default_nettype none

module lesson_tracker #(
	parameter int BEAT_CYCLES = 64,
	parameter int MISTAKE_MAX = 1000
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  keyboard_pkg::mode_t                mode,
	input  song_pkg::song_id_t                 song_num,
	input  keyboard_pkg::note_t                pressed_note,
	output keyboard_pkg::note_t                play_note,
	output keyboard_pkg::led_t                 led,
	output logic                               finished,
	output logic [$clog2(MISTAKE_MAX + 1)-1:0] score
);

	import keyboard_pkg::*;
	import song_pkg::*;

	localparam int SCORE_W = $clog2(MISTAKE_MAX + 1);
	localparam int HOLD_W  = $clog2(BEAT_CYCLES);
	localparam int IDX_W   = $clog2(MAX_STEPS);

	localparam logic [SCORE_W-1:0] SCORE_MAX   = SCORE_W'(MISTAKE_MAX);
	localparam logic [HOLD_W-1:0]  SINGLE_LAST = HOLD_W'(BEAT_CYCLES - 1);
	localparam logic [HOLD_W-1:0]  DOUBLE_LAST = HOLD_W'(BEAT_CYCLES / 2 - 1);

	step_t             step;
	logic [HOLD_W-1:0] hold_cnt;
	song_id_t          last_song;

	logic              learn;
	logic              song_ok;
	logic              restart;
	note_t             exp_note;
	len_t              exp_len;
	logic [HOLD_W-1:0] hold_last;
	logic              match;
	logic              wrong;

	assign learn   = (mode == MODE_LEARN);
	assign song_ok = (song_num < SONG_COUNT);
	assign restart = !learn || (song_num != last_song);

	assign exp_note  = SONG_NOTE[song_num][step[IDX_W-1:0]];
	assign exp_len   = SONG_LEN[song_num][step[IDX_W-1:0]];
	assign hold_last = (exp_len == LEN_DOUBLE) ? DOUBLE_LAST : SINGLE_LAST;

	assign match = (pressed_note == exp_note);  // A rest matches no key
	assign wrong = (pressed_note != '0) && !match;

	assign led = (learn && song_ok && exp_note != '0) ?
		led_t'(1) << note_degree(exp_note) : '0;
	assign play_note = (learn && song_ok && match) ? pressed_note : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step      <= '0;
			hold_cnt  <= '0;
			finished  <= 1'b0;
			last_song <= '0;
		end else if (restart) begin
			step      <= '0;
			hold_cnt  <= '0;
			finished  <= 1'b0;
			last_song <= song_num;
		end else if (song_ok) begin
			if (!match) begin
				hold_cnt <= '0;
			end else if (hold_cnt == hold_last) begin
				hold_cnt <= '0;
				if (step == SONG_LAST[song_num]) begin
					step     <= '0;  // Wrap for another pass
					finished <= 1'b1;
				end else begin
					step <= step + 5'd1;
				end
			end else begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	// Saturating count of wrong-key cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			score <= '0;
		end else if (restart) begin
			score <= '0;
		end else if (song_ok && wrong && score != SCORE_MAX) begin
			score <= score + 1'b1;
		end
	end

	a_step_in_song: assert property (
		@(posedge clk) disable iff (!rst_n)
		step <= SONG_LAST[last_song]
	);

	a_score_cap: assert property (
		@(posedge clk) disable iff (!rst_n)
		score <= SCORE_MAX
	);

	// Only a restart may drop the finished flag
	a_finished_holds: assert property (
		@(posedge clk) disable iff (!rst_n)
		finished && !restart |=> finished
	);

endmodule

`default_nettype wire

// File: design/tone_gen.sv
// Buzzer tone generator
`timescale 1ns/1ns
`default_nettype none

module tone_gen #(
	parameter int CLK_HZ = 100000
) (
	input  logic                clk,
	input  logic                rst_n,
	input  keyboard_pkg::note_t play_note,
	output logic                speaker
);

	import keyboard_pkg::*;

	// Lowest note gives the longest half period
	localparam int CNT_W = $clog2(CLK_HZ / (2 * NOTE_HZ[0]) + 1);

	logic [CNT_W-1:0] half_tab [NOTE_COUNT];
	logic [CNT_W-1:0] half_cur;
	logic [CNT_W-1:0] cnt;
	note_t            last_note;

	for (genvar g = 0; g < NOTE_COUNT; g++) begin : g_half
		assign half_tab[g] = CNT_W'(CLK_HZ / (2 * NOTE_HZ[g]));
	end

	assign half_cur = (play_note != '0) ? half_tab[play_note - 5'd1] : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			speaker   <= 1'b0;
			cnt       <= '0;
			last_note <= '0;
		end else if (play_note == '0) begin
			speaker   <= 1'b0;
			cnt       <= '0;
			last_note <= '0;
		end else if (play_note != last_note) begin
			cnt       <= half_cur - 1'b1;  // New note restarts the count
			last_note <= play_note;
		end else if (cnt == '0) begin
			speaker <= ~speaker;
			cnt     <= half_cur - 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	a_silent_low: assert property (
		@(posedge clk) disable iff (!rst_n)
		play_note == '0 |=> !speaker
	);

endmodule

`default_nettype wire

// File: design/learning_top.sv
// Learning mode top level
`timescale 1ns/1ns
`default_nettype none

module learning_top #(
	parameter int BEAT_CYCLES = 64,     // Must be even
	parameter int MISTAKE_MAX = 1000,
	parameter int CLK_HZ      = 100000  // Simulation clock rate
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  keyboard_pkg::key_t                 key,
	input  keyboard_pkg::pitch_t               pitch,
	input  keyboard_pkg::mode_t                mode,
	input  song_pkg::song_id_t                 song_num,
	output logic                               speaker,
	output keyboard_pkg::led_t                 led,
	output logic                               finished,
	output logic [$clog2(MISTAKE_MAX + 1)-1:0] score
);

	import keyboard_pkg::*;

	note_t pressed_note;
	note_t play_note;  // Pressed note, only when it matches

	key_decoder u_key_decoder (
		.key          (key),
		.pitch        (pitch),
		.pressed_note (pressed_note)
	);

	lesson_tracker #(
		.BEAT_CYCLES (BEAT_CYCLES),
		.MISTAKE_MAX (MISTAKE_MAX)
	) u_lesson_tracker (
		.clk          (clk),
		.rst_n        (rst_n),
		.mode         (mode),
		.song_num     (song_num),
		.pressed_note (pressed_note),
		.play_note    (play_note),
		.led          (led),
		.finished     (finished),
		.score        (score)
	);

	tone_gen #(
		.CLK_HZ (CLK_HZ)
	) u_tone_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.play_note (play_note),
		.speaker   (speaker)
	);

endmodule

`default_nettype wire

// File: verif/tb_learning_tasks.svh
// Learning keyboard test tasks
`ifndef TB_LEARNING_TASKS_SVH
`define TB_LEARNING_TASKS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic key_t key_for_note(input note_t n);
	if (n == '0) return '0;
	return key_t'(1) << ((int'(n) - 1) % DEGREES);
endfunction

function automatic pitch_t pitch_for_note(input note_t n);
	if (n == '0) return PITCH_MID;
	case ((int'(n) - 1) / DEGREES)
		0:       return PITCH_LOW;
		2:       return PITCH_HIGH;
		default: return PITCH_MID;
	endcase
endfunction

// One-hot scale degree, dark on a rest
function automatic led_t led_for_note(input note_t n);
	if (n == '0) return '0;
	return led_t'(1) << ((int'(n) - 1) % DEGREES);
endfunction

function automatic int hold_target(input int s, input int i);
	return (SONG_LEN[s][i] == LEN_DOUBLE) ? BEAT_CYCLES / 2 : BEAT_CYCLES;
endfunction

function automatic note_t pick_wrong_note(input logic [31:0] r, input note_t right);
	int deg;
	int grp;
	int n;
	deg = int'(r[7:0]) % DEGREES;
	grp = int'(r[15:8]) % 3;
	n   = grp * DEGREES + deg + 1;
	if (n == int'(right)) n = (n % 21) + 1;  // Step off the right note
	return note_t'(n);
endfunction

task automatic compare_led(input led_t got, input led_t exp);
	if (got !== exp) begin
		$display("** Error at %0t: led expected %b got %b", $time, exp, got);
		errors++;
	end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("** Error at %0t: %s expected %b got %b", $time, name, exp, got);
		errors++;
	end
endtask

task automatic compare_score(input score_t got, input score_t exp);
	if (got !== exp) begin
		$display("** Error at %0t: score expected %0d got %0d", $time, exp, got);
		errors++;
	end
endtask

// Tasks start and end just after a rising edge
task automatic play_step(input int s, input int i);
	note_t n;
	int    target;
	n      = SONG_NOTE[s][i];
	target = hold_target(s, i);
	key   <= key_for_note(n);
	pitch <= pitch_for_note(n);
	@(negedge clk);
	compare_led(led, led_for_note(n));
	repeat (target) @(posedge clk);
endtask

task automatic play_song(input int s);
	for (int i = 0; i <= int'(SONG_LAST[s]); i++) begin
		play_step(s, i);
	end
endtask

task automatic test_idle();
	note_t n;
	int    half;
	n    = SONG_NOTE[0][0];
	half = CLK_HZ / (2 * NOTE_HZ[int'(n) - 1]);
	mode <= 3'b010;
	repeat (8) begin
		rng_state = xorshift32(rng_state);
		key   <= rng_state[7:0];
		pitch <= rng_state[9:8];
		@(negedge clk);
		compare_led(led, '0);
		compare_score(score, '0);
		compare_bit("finished", finished, 1'b0);
		compare_bit("speaker", speaker, 1'b0);
		@(posedge clk);
	end
	// First note of song 0 would sound within one half period
	key   <= key_for_note(n);
	pitch <= pitch_for_note(n);
	repeat (half + 4) begin
		@(negedge clk);
		compare_led(led, '0);
		compare_bit("speaker", speaker, 1'b0);
		@(posedge clk);
	end
	key <= '0;
endtask

task automatic test_full_lesson();
	mode     <= MODE_LEARN;
	song_num <= SONG_TWINKLE;
	key      <= '0;
	@(posedge clk);
	play_song(0);
	key <= '0;
	@(negedge clk);
	compare_bit("finished", finished, 1'b1);
	compare_led(led, led_for_note(SONG_NOTE[0][0]));
	compare_score(score, '0);
	@(posedge clk);
endtask

task automatic test_double_and_score();
	note_t first;
	note_t wrong;
	int    wrong_cycles;
	song_num <= SONG_ODE;
	key      <= '0;
	@(posedge clk);  // Restart edge
	first = SONG_NOTE[1][0];
	key   <= key_for_note(first);
	pitch <= pitch_for_note(first);
	repeat (hold_target(1, 0) - 1) @(posedge clk);
	key <= '0;
	@(posedge clk);
	@(negedge clk);
	compare_led(led, led_for_note(first));
	compare_score(score, '0);
	@(posedge clk);
	rng_state = xorshift32(rng_state);
	wrong        = pick_wrong_note(rng_state, first);
	wrong_cycles = 5 + int'(rng_state[18:16]);
	key   <= key_for_note(wrong);
	pitch <= pitch_for_note(wrong);
	repeat (wrong_cycles) @(posedge clk);
	key <= '0;
	@(negedge clk);
	compare_score(score, score_t'(wrong_cycles));
	@(posedge clk);
	play_song(1);  // Steps 0 and 1 prove the short hold did not advance
	key <= '0;
	@(negedge clk);
	compare_bit("finished", finished, 1'b1);
	compare_score(score, score_t'(wrong_cycles));
	compare_led(led, led_for_note(SONG_NOTE[1][0]));
	@(posedge clk);
endtask

task automatic test_restart();
	note_t wrong;
	song_num <= SONG_TWINKLE;
	@(posedge clk);
	@(negedge clk);
	compare_score(score, '0);
	compare_bit("finished", finished, 1'b0);
	compare_led(led, led_for_note(SONG_NOTE[0][0]));
	@(posedge clk);
	play_song(0);  // Finished again before leaving the mode
	rng_state = xorshift32(rng_state);
	wrong = pick_wrong_note(rng_state, SONG_NOTE[0][0]);
	key   <= key_for_note(wrong);
	pitch <= pitch_for_note(wrong);
	repeat (3) @(posedge clk);
	key <= '0;
	@(negedge clk);
	compare_score(score, score_t'(3));
	compare_bit("finished", finished, 1'b1);
	@(posedge clk);
	mode <= 3'b001;  // Leave learning mode
	@(posedge clk);
	@(negedge clk);
	compare_score(score, '0);
	compare_led(led, '0);
	compare_bit("finished", finished, 1'b0);
	@(posedge clk);
	mode <= MODE_LEARN;
	@(negedge clk);
	compare_led(led, led_for_note(SONG_NOTE[0][0]));
	@(posedge clk);
	song_num <= 2'd2;
	key      <= '0;  // An empty song holds only rests
	repeat (BEAT_CYCLES + 4) begin
		@(negedge clk);
		compare_led(led, '0);
		compare_bit("finished", finished, 1'b0);
		@(posedge clk);
	end
	song_num <= SONG_TWINKLE;
	@(posedge clk);
endtask

task automatic test_tone();
	note_t n;
	note_t wrong;
	int    half;
	int    waited;
	n     = SONG_NOTE[0][0];
	half  = CLK_HZ / (2 * NOTE_HZ[int'(n) - 1]);
	key   <= key_for_note(n);
	pitch <= pitch_for_note(n);
	waited = 0;
	@(negedge clk);
	while (speaker !== 1'b1 && waited < 2 * half + 4) begin
		@(negedge clk);
		waited++;
	end
	if (speaker !== 1'b1) begin
		$display("Error at %0t: speaker never went high while the right note was held", $time);
		errors++;
	end else begin
		repeat (half - 1) begin
			@(negedge clk);
			compare_bit("speaker", speaker, 1'b1);
		end
		@(negedge clk);
		compare_bit("speaker", speaker, 1'b0);
	end
	@(posedge clk);
	rng_state = xorshift32(rng_state);
	wrong = pick_wrong_note(rng_state, SONG_NOTE[0][0]);
	half  = CLK_HZ / (2 * NOTE_HZ[int'(wrong) - 1]);
	key   <= key_for_note(wrong);
	pitch <= pitch_for_note(wrong);
	@(posedge clk);
	repeat (half + 4) begin  // Past the first toggle of the wrong note
		@(negedge clk);
		compare_bit("speaker", speaker, 1'b0);
		@(posedge clk);
	end
	key <= '0;
endtask

`endif

// File: verif/tb_learning.sv
// Learning keyboard testbench
`timescale 1ns/1ns
`default_nettype none

module tb_learning;

	import keyboard_pkg::*;
	import song_pkg::*;

	localparam int BEAT_CYCLES = 512;    // Long enough for a full tone period
	localparam int MISTAKE_MAX = 1000;
	localparam int CLK_HZ      = 100000;
	localparam int SCORE_W     = $clog2(MISTAKE_MAX + 1);
	localparam int CLK_NS      = 8;

	// Both songs, three times over, plus slack for the short tests
	localparam int     LESSON_STEPS = int'(SONG_LAST[0]) + int'(SONG_LAST[1]) + 2;
	localparam longint WATCHDOG_NS  =
		longint'(LESSON_STEPS) * BEAT_CYCLES * 3 * CLK_NS + 40000;

	typedef logic [SCORE_W-1:0] score_t;

	logic     clk;
	logic     rst_n;
	key_t     key;
	pitch_t   pitch;
	mode_t    mode;
	song_id_t song_num;
	logic     speaker;
	led_t     led;
	logic     finished;
	score_t   score;

	int          errors;
	logic [31:0] rng_state;

	learning_top #(
		.BEAT_CYCLES (BEAT_CYCLES),
		.MISTAKE_MAX (MISTAKE_MAX),
		.CLK_HZ      (CLK_HZ)
	) dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.key      (key),
		.pitch    (pitch),
		.mode     (mode),
		.song_num (song_num),
		.speaker  (speaker),
		.led      (led),
		.finished (finished),
		.score    (score)
	);

	initial clk = 1'b0;

	always #(CLK_NS / 2) clk = ~clk;

	`include "tb_learning_tasks.svh"

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished, %0d errors so far", errors);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst_n     = 1'b0;
		key       = '0;
		pitch     = PITCH_MID;
		mode      = 3'b000;
		song_num  = SONG_TWINKLE;
		errors    = 0;
		rng_state = 32'hdcc4_9c5f;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		test_idle();
		test_full_lesson();
		test_double_and_score();
		test_restart();
		test_tone();

		@(negedge clk);
		$display("Tests done with %0d errors", errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: learning_keyboard.f
+incdir+verif
design/keyboard_pkg.sv
design/song_pkg.sv
design/key_decoder.sv
design/lesson_tracker.sv
design/tone_gen.sv
design/learning_top.sv
verif/tb_learning.sv

// File: run.sh
#!/bin/sh
# Builds the learning keyboard testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f learning_keyboard.f \
	--top-module tb_learning \
	-o sim_learning

out=$(./obj_dir/sim_learning)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
	exit 0
else
	exit 1
fi
